/* hw/lc3b_pkg.sv */
package lc3b_pkg;

localparam int lc3b_word_w = 16;
localparam int lc3b_reg_cnt = 8;
localparam int lc3b_reg_w = 3;

typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [2:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass,
	alu_sll,
	alu_srl,
	alu_sra
} lc3b_aluop;

// imm5 is {shift_type, low4}, sr2 and imm4 sit in low4
typedef union packed {
	struct packed {
		lc3b_opcode            opcode;
		logic [lc3b_reg_w-1:0] dr;
		logic [lc3b_reg_w-1:0] sr1;
		logic                  mode;
		logic                  shift_type;
		logic [3:0]            low4;
	} opr;
	struct packed {
		lc3b_opcode            opcode;
		logic [lc3b_reg_w-1:0] dr;
		logic [lc3b_reg_w-1:0] base;
		logic [5:0]            offset6;
	} mem;
	// offset11 and trapvect8 are slices of this view
	struct packed {
		lc3b_opcode            opcode;
		logic [lc3b_reg_w-1:0] dr;
		logic [8:0]            offset9;
	} pcr;
} lc3b_instr;

endpackage : lc3b_pkg

/* hw/decode.sv */
`timescale 1ns/100ps

module decode (
	input  lc3b_pkg::lc3b_instr              instr,
	output logic [lc3b_pkg::lc3b_reg_w-1:0]  sr1_addr,
	output logic [lc3b_pkg::lc3b_reg_w-1:0]  sr2_addr,
	output logic [lc3b_pkg::lc3b_reg_w-1:0]  dest_addr,
	output logic                             sh6_sel,
	output logic                             imm_sel,
	output logic [1:0]                       alumux1_sel,
	output logic [1:0]                       alumux2_sel,
	output lc3b_pkg::lc3b_aluop              alu_ctrl,
	output logic                             indirect,
	output logic                             read,
	output logic                             write,
	output logic [1:0]                       mem_byte_sig,
	output logic                             regfilemux_sel,
	output logic                             load_regfile,
	output logic                             memread_sel,
	output logic                             load_cc,
	output logic [1:0]                       pcmux_sel,
	output logic                             pcmux_sel_out_sel
);
	import lc3b_pkg::*;

	logic sr2_sel;
	logic destmux_sel;

	always_comb begin
		sr2_sel = 1'b0;
		destmux_sel = 1'b0;
		sh6_sel = 1'b0;
		imm_sel = 1'b0;
		alumux1_sel = 2'b00;
		alumux2_sel = 2'b00;
		alu_ctrl = alu_add;
		indirect = 1'b0;
		read = 1'b0;
		write = 1'b0;
		mem_byte_sig = 2'b00;
		regfilemux_sel = 1'b0;
		load_regfile = 1'b0;
		memread_sel = 1'b0;
		load_cc = 1'b0;
		pcmux_sel = 2'b00;
		pcmux_sel_out_sel = 1'b0;

		case (instr.opr.opcode)
			op_add, op_and: begin
				// Bit 5 picks imm5 over sr2
				alumux2_sel = instr.opr.mode ? 2'b11 : 2'b00;
				alu_ctrl = (instr.opr.opcode == op_and) ? alu_and : alu_add;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			op_not: begin
				alu_ctrl = alu_not;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			op_ldb, op_ldr, op_ldi: begin
				sh6_sel = (instr.opr.opcode != op_ldb);
				alumux2_sel = 2'b01;
				indirect = (instr.opr.opcode == op_ldi);
				read = 1'b1;
				if (instr.opr.opcode == op_ldb)
					mem_byte_sig = 2'b01;
				else if (instr.opr.opcode == op_ldr)
					mem_byte_sig = 2'b11;
				load_regfile = 1'b1;
				load_cc = 1'b1;
				memread_sel = 1'b1;
			end
			op_stb, op_str, op_sti: begin
				// Store data comes from the dr field
				sr2_sel = 1'b1;
				sh6_sel = (instr.opr.opcode != op_stb);
				alumux2_sel = 2'b01;
				indirect = (instr.opr.opcode == op_sti);
				write = 1'b1;
				if (instr.opr.opcode == op_stb)
					mem_byte_sig = 2'b01;
				else if (instr.opr.opcode == op_str)
					mem_byte_sig = 2'b11;
			end
			op_br: begin
				alumux1_sel = 2'b01;
				alumux2_sel = 2'b10;
				pcmux_sel_out_sel = 1'b1;
			end
			op_jmp: begin
				alu_ctrl = alu_pass;
				pcmux_sel = 2'b01;
			end
			op_jsr: begin
				if (instr.pcr.dr[2]) begin
					// PC plus offset11
					alumux1_sel = 2'b10;
					alumux2_sel = 2'b10;
				end else begin
					alu_ctrl = alu_pass;
				end
				destmux_sel = 1'b1;
				regfilemux_sel = 1'b1;
				load_regfile = 1'b1;
				pcmux_sel = 2'b01;
			end
			op_lea: begin
				alumux1_sel = 2'b01;
				alumux2_sel = 2'b10;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			op_shf: begin
				imm_sel = 1'b1;
				if (!instr.opr.shift_type)
					alu_ctrl = alu_sll;
				else if (instr.opr.mode)
					alu_ctrl = alu_sra;
				else
					alu_ctrl = alu_srl;
				load_regfile = 1'b1;
				load_cc = 1'b1;
			end
			op_trap: begin
				alumux1_sel = 2'b11;
				alu_ctrl = alu_pass;
				destmux_sel = 1'b1;
				regfilemux_sel = 1'b1;
				load_regfile = 1'b1;
				pcmux_sel = 2'b11;
			end
			op_rti: begin
				// Not implemented so it stays all zero
			end
		endcase
	end

	assign sr1_addr = instr.opr.sr1;
	assign sr2_addr = sr2_sel ? instr.opr.dr : instr.opr.low4[lc3b_reg_w-1:0];
	// R7 takes the return address
	assign dest_addr = destmux_sel ? lc3b_reg_w'(7) : instr.opr.dr;

endmodule : decode

/* hw/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen (
	input  lc3b_pkg::lc3b_instr                instr,
	input  logic [1:0]                         alumux1_sel,
	input  logic [1:0]                         alumux2_sel,
	input  logic                               sh6_sel,
	input  logic                               imm_sel,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   imm,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   trapvec
);
	import lc3b_pkg::*;

	logic [4:0]  imm5;
	logic [5:0]  off6;
	logic [8:0]  off9;
	logic [10:0] off11;
	logic [7:0]  tv8;

	assign imm5 = {instr.opr.shift_type, instr.opr.low4};
	assign off6 = instr.mem.offset6;
	assign off9 = instr.pcr.offset9;
	assign off11 = {instr.pcr.dr[1:0], instr.pcr.offset9};
	assign tv8 = instr.pcr.offset9[7:0];

	always_comb begin
		if (imm_sel) begin
			// Shift amount
			imm = {{(lc3b_word_w-4){1'b0}}, instr.opr.low4};
		end else begin
			case (alumux2_sel)
				2'b01: imm = sh6_sel ? {{(lc3b_word_w-7){off6[5]}}, off6, 1'b0}
				                     : {{(lc3b_word_w-6){off6[5]}}, off6};
				2'b10: imm = (alumux1_sel == 2'b10) ? {{(lc3b_word_w-12){off11[10]}}, off11, 1'b0}
				                                    : {{(lc3b_word_w-10){off9[8]}}, off9, 1'b0};
				2'b11: imm = {{(lc3b_word_w-5){imm5[4]}}, imm5};
				default: imm = '0;
			endcase
		end
	end

	assign trapvec = {{(lc3b_word_w-9){1'b0}}, tv8, 1'b0};

endmodule : imm_gen

/* hw/regfile.sv */
`timescale 1ns/100ps

module regfile (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               wb_load,
	input  logic [lc3b_pkg::lc3b_reg_w-1:0]    wb_dest,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]   wb_data,
	input  logic [lc3b_pkg::lc3b_reg_w-1:0]    sr1_addr,
	input  logic [lc3b_pkg::lc3b_reg_w-1:0]    sr2_addr,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   sr1_data,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   sr2_data
);
	import lc3b_pkg::*;

	logic [lc3b_word_w-1:0] regs [lc3b_reg_cnt];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < lc3b_reg_cnt; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_load) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// Writeback in the same cycle is forwarded to the readers
	assign sr1_data = (wb_load && (wb_dest == sr1_addr)) ? wb_data : regs[sr1_addr];
	assign sr2_data = (wb_load && (wb_dest == sr2_addr)) ? wb_data : regs[sr2_addr];

	a_wb_dest_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		wb_load |-> !$isunknown(wb_dest)
	);

endmodule : regfile

/* hw/id_ex_reg.sv */
`timescale 1ns/100ps

module id_ex_reg (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               stall,
	input  logic                               flush,
	input  logic                               instr_valid,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]   pc,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]   sr1_data,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]   sr2_data,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]   imm,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]   trapvec,
	input  logic [lc3b_pkg::lc3b_reg_w-1:0]    dest_addr,
	input  logic [1:0]                         alumux1_sel,
	input  logic [1:0]                         alumux2_sel,
	input  lc3b_pkg::lc3b_aluop                alu_ctrl,
	input  logic                               indirect,
	input  logic                               read,
	input  logic                               write,
	input  logic [1:0]                         mem_byte_sig,
	input  logic                               regfilemux_sel,
	input  logic                               load_regfile,
	input  logic                               memread_sel,
	input  logic                               load_cc,
	input  logic [1:0]                         pcmux_sel,
	input  logic                               pcmux_sel_out_sel,
	output logic                               ex_valid,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_pc,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_sr1_data,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_sr2_data,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_imm,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_trapvec,
	output logic [lc3b_pkg::lc3b_reg_w-1:0]    ex_dest,
	output logic [1:0]                         ex_alumux1_sel,
	output logic [1:0]                         ex_alumux2_sel,
	output lc3b_pkg::lc3b_aluop                ex_alu_ctrl,
	output logic                               ex_indirect,
	output logic                               ex_read,
	output logic                               ex_write,
	output logic [1:0]                         ex_mem_byte_sig,
	output logic                               ex_regfilemux_sel,
	output logic                               ex_load_regfile,
	output logic                               ex_memread_sel,
	output logic                               ex_load_cc,
	output logic [1:0]                         ex_pcmux_sel,
	output logic                               ex_pcmux_sel_out_sel
);
	import lc3b_pkg::*;

	// Valid and side-effect strobes
	// Flush wins over stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex_read <= 1'b0;
			ex_write <= 1'b0;
			ex_load_regfile <= 1'b0;
			ex_load_cc <= 1'b0;
		end else if (flush) begin
			ex_valid <= 1'b0;
			ex_read <= 1'b0;
			ex_write <= 1'b0;
			ex_load_regfile <= 1'b0;
			ex_load_cc <= 1'b0;
		end else if (!stall) begin
			ex_valid <= instr_valid;
			ex_read <= read & instr_valid;
			ex_write <= write & instr_valid;
			ex_load_regfile <= load_regfile & instr_valid;
			ex_load_cc <= load_cc & instr_valid;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_alumux1_sel <= 2'b00;
			ex_alumux2_sel <= 2'b00;
			ex_alu_ctrl <= alu_add;
			ex_indirect <= 1'b0;
			ex_mem_byte_sig <= 2'b00;
			ex_regfilemux_sel <= 1'b0;
			ex_memread_sel <= 1'b0;
			ex_pcmux_sel <= 2'b00;
			ex_pcmux_sel_out_sel <= 1'b0;
		end else if (!stall) begin
			ex_alumux1_sel <= alumux1_sel;
			ex_alumux2_sel <= alumux2_sel;
			ex_alu_ctrl <= alu_ctrl;
			ex_indirect <= indirect;
			ex_mem_byte_sig <= mem_byte_sig;
			ex_regfilemux_sel <= regfilemux_sel;
			ex_memread_sel <= memread_sel;
			ex_pcmux_sel <= pcmux_sel;
			ex_pcmux_sel_out_sel <= pcmux_sel_out_sel;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_pc <= pc;
			ex_sr1_data <= sr1_data;
			ex_sr2_data <= sr2_data;
			ex_imm <= imm;
			ex_trapvec <= trapvec;
			ex_dest <= dest_addr;
		end
	end

endmodule : id_ex_reg

/* hw/lc3b_id_top.sv */
`timescale 1ns/100ps

module lc3b_id_top (
	input  logic                               clk,
	input  logic                               arst_n,
	input  lc3b_pkg::lc3b_instr                instr,
	input  logic                               instr_valid,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]   pc,
	input  logic                               stall,
	input  logic                               flush,
	input  logic                               wb_load,
	input  logic [lc3b_pkg::lc3b_reg_w-1:0]    wb_dest,
	input  logic [lc3b_pkg::lc3b_word_w-1:0]   wb_data,
	output logic                               ex_valid,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_pc,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_sr1_data,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_sr2_data,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_imm,
	output logic [lc3b_pkg::lc3b_word_w-1:0]   ex_trapvec,
	output logic [lc3b_pkg::lc3b_reg_w-1:0]    ex_dest,
	output logic [1:0]                         ex_alumux1_sel,
	output logic [1:0]                         ex_alumux2_sel,
	output lc3b_pkg::lc3b_aluop                ex_alu_ctrl,
	output logic                               ex_indirect,
	output logic                               ex_read,
	output logic                               ex_write,
	output logic [1:0]                         ex_mem_byte_sig,
	output logic                               ex_regfilemux_sel,
	output logic                               ex_load_regfile,
	output logic                               ex_memread_sel,
	output logic                               ex_load_cc,
	output logic [1:0]                         ex_pcmux_sel,
	output logic                               ex_pcmux_sel_out_sel
);
	import lc3b_pkg::*;

	logic [lc3b_reg_w-1:0]  sr1_addr;
	logic [lc3b_reg_w-1:0]  sr2_addr;
	logic [lc3b_reg_w-1:0]  dest_addr;
	logic                   sh6_sel;
	logic                   imm_sel;
	logic [1:0]             alumux1_sel;
	logic [1:0]             alumux2_sel;
	lc3b_aluop              alu_ctrl;
	logic                   indirect;
	logic                   read;
	logic                   write;
	logic [1:0]             mem_byte_sig;
	logic                   regfilemux_sel;
	logic                   load_regfile;
	logic                   memread_sel;
	logic                   load_cc;
	logic [1:0]             pcmux_sel;
	logic                   pcmux_sel_out_sel;
	logic [lc3b_word_w-1:0] sr1_data;
	logic [lc3b_word_w-1:0] sr2_data;
	logic [lc3b_word_w-1:0] imm;
	logic [lc3b_word_w-1:0] trapvec;

	decode u_decode (
		.instr             (instr),
		.sr1_addr          (sr1_addr),
		.sr2_addr          (sr2_addr),
		.dest_addr         (dest_addr),
		.sh6_sel           (sh6_sel),
		.imm_sel           (imm_sel),
		.alumux1_sel       (alumux1_sel),
		.alumux2_sel       (alumux2_sel),
		.alu_ctrl          (alu_ctrl),
		.indirect          (indirect),
		.read              (read),
		.write             (write),
		.mem_byte_sig      (mem_byte_sig),
		.regfilemux_sel    (regfilemux_sel),
		.load_regfile      (load_regfile),
		.memread_sel       (memread_sel),
		.load_cc           (load_cc),
		.pcmux_sel         (pcmux_sel),
		.pcmux_sel_out_sel (pcmux_sel_out_sel)
	);

	imm_gen u_imm_gen (
		.instr       (instr),
		.alumux1_sel (alumux1_sel),
		.alumux2_sel (alumux2_sel),
		.sh6_sel     (sh6_sel),
		.imm_sel     (imm_sel),
		.imm         (imm),
		.trapvec     (trapvec)
	);

	regfile u_regfile (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_load  (wb_load),
		.wb_dest  (wb_dest),
		.wb_data  (wb_data),
		.sr1_addr (sr1_addr),
		.sr2_addr (sr2_addr),
		.sr1_data (sr1_data),
		.sr2_data (sr2_data)
	);

	id_ex_reg u_id_ex_reg (
		.clk                  (clk),
		.arst_n               (arst_n),
		.stall                (stall),
		.flush                (flush),
		.instr_valid          (instr_valid),
		.pc                   (pc),
		.sr1_data             (sr1_data),
		.sr2_data             (sr2_data),
		.imm                  (imm),
		.trapvec              (trapvec),
		.dest_addr            (dest_addr),
		.alumux1_sel          (alumux1_sel),
		.alumux2_sel          (alumux2_sel),
		.alu_ctrl             (alu_ctrl),
		.indirect             (indirect),
		.read                 (read),
		.write                (write),
		.mem_byte_sig         (mem_byte_sig),
		.regfilemux_sel       (regfilemux_sel),
		.load_regfile         (load_regfile),
		.memread_sel          (memread_sel),
		.load_cc              (load_cc),
		.pcmux_sel            (pcmux_sel),
		.pcmux_sel_out_sel    (pcmux_sel_out_sel),
		.ex_valid             (ex_valid),
		.ex_pc                (ex_pc),
		.ex_sr1_data          (ex_sr1_data),
		.ex_sr2_data          (ex_sr2_data),
		.ex_imm               (ex_imm),
		.ex_trapvec           (ex_trapvec),
		.ex_dest              (ex_dest),
		.ex_alumux1_sel       (ex_alumux1_sel),
		.ex_alumux2_sel       (ex_alumux2_sel),
		.ex_alu_ctrl          (ex_alu_ctrl),
		.ex_indirect          (ex_indirect),
		.ex_read              (ex_read),
		.ex_write             (ex_write),
		.ex_mem_byte_sig      (ex_mem_byte_sig),
		.ex_regfilemux_sel    (ex_regfilemux_sel),
		.ex_load_regfile      (ex_load_regfile),
		.ex_memread_sel       (ex_memread_sel),
		.ex_load_cc           (ex_load_cc),
		.ex_pcmux_sel         (ex_pcmux_sel),
		.ex_pcmux_sel_out_sel (ex_pcmux_sel_out_sel)
	);

endmodule : lc3b_id_top

/* testbench/id_ref_model.sv */
`timescale 1ns/100ps

module id_ref_model (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [15:0] instr,
	input  logic        instr_valid,
	input  logic [15:0] pc,
	input  logic        stall,
	input  logic        flush,
	input  logic        wb_load,
	input  logic [2:0]  wb_dest,
	input  logic [15:0] wb_data,
	output logic        exp_valid,
	output logic [15:0] exp_pc,
	output logic [15:0] exp_sr1_data,
	output logic [15:0] exp_sr2_data,
	output logic [15:0] exp_imm,
	output logic [15:0] exp_trapvec,
	output logic [2:0]  exp_dest,
	output logic [1:0]  exp_alumux1_sel,
	output logic [1:0]  exp_alumux2_sel,
	output logic [2:0]  exp_alu_ctrl,
	output logic        exp_indirect,
	output logic        exp_read,
	output logic        exp_write,
	output logic [1:0]  exp_mem_byte_sig,
	output logic        exp_regfilemux_sel,
	output logic        exp_load_regfile,
	output logic        exp_memread_sel,
	output logic        exp_load_cc,
	output logic [1:0]  exp_pcmux_sel,
	output logic        exp_pcmux_sel_out_sel
);
	import lc3b_pkg::*;

	logic [15:0] shadow [8];
	logic [1:0]  a1;
	logic [1:0]  a2;
	logic [2:0]  alu;
	logic        ind;
	logic        rd;
	logic        wr;
	logic [1:0]  mbs;
	logic        rfm;
	logic        ldr;
	logic        mrs;
	logic        lcc;
	logic [1:0]  pcm;
	logic        pcos;
	logic        sh6;
	logic        shamt;
	logic        store;
	logic        link;
	logic [2:0]  sr1a;
	logic [2:0]  sr2a;
	logic [2:0]  dsta;
	logic [15:0] immv;
	logic [15:0] rd1;
	logic [15:0] rd2;

	// Control table per opcode
	always @* begin
		a1 = 2'b00;
		a2 = 2'b00;
		alu = alu_add;
		ind = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		mbs = 2'b00;
		rfm = 1'b0;
		ldr = 1'b0;
		mrs = 1'b0;
		lcc = 1'b0;
		pcm = 2'b00;
		pcos = 1'b0;
		sh6 = 1'b0;
		shamt = 1'b0;
		store = 1'b0;
		link = 1'b0;
		case (instr[15:12])
			op_add, op_and: begin
				a2 = instr[5] ? 2'b11 : 2'b00;
				if (instr[15:12] == op_and)
					alu = alu_and;
				ldr = 1'b1;
				lcc = 1'b1;
			end
			op_not: begin
				alu = alu_not;
				ldr = 1'b1;
				lcc = 1'b1;
			end
			op_ldb, op_ldr, op_ldi: begin
				a2 = 2'b01;
				sh6 = (instr[15:12] != op_ldb);
				ind = (instr[15:12] == op_ldi);
				rd = 1'b1;
				mbs = (instr[15:12] == op_ldb) ? 2'b01 : (instr[15:12] == op_ldr) ? 2'b11 : 2'b00;
				ldr = 1'b1;
				lcc = 1'b1;
				mrs = 1'b1;
			end
			op_stb, op_str, op_sti: begin
				store = 1'b1;
				a2 = 2'b01;
				sh6 = (instr[15:12] != op_stb);
				ind = (instr[15:12] == op_sti);
				wr = 1'b1;
				mbs = (instr[15:12] == op_stb) ? 2'b01 : (instr[15:12] == op_str) ? 2'b11 : 2'b00;
			end
			op_br, op_lea: begin
				a1 = 2'b01;
				a2 = 2'b10;
				pcos = (instr[15:12] == op_br);
				ldr = (instr[15:12] == op_lea);
				lcc = (instr[15:12] == op_lea);
			end
			op_jmp: begin
				alu = alu_pass;
				pcm = 2'b01;
			end
			op_jsr: begin
				// JSR with PC offset when bit 11 set, JSRR otherwise
				if (instr[11]) begin
					a1 = 2'b10;
					a2 = 2'b10;
				end else begin
					alu = alu_pass;
				end
				link = 1'b1;
				rfm = 1'b1;
				ldr = 1'b1;
				pcm = 2'b01;
			end
			op_shf: begin
				shamt = 1'b1;
				alu = !instr[4] ? alu_sll : instr[5] ? alu_sra : alu_srl;
				ldr = 1'b1;
				lcc = 1'b1;
			end
			op_trap: begin
				a1 = 2'b11;
				alu = alu_pass;
				link = 1'b1;
				rfm = 1'b1;
				ldr = 1'b1;
				pcm = 2'b11;
			end
			default: begin
			end
		endcase

		sr1a = instr[8:6];
		sr2a = store ? instr[11:9] : instr[2:0];
		dsta = link ? 3'd7 : instr[11:9];
		if (shamt)
			immv = {12'd0, instr[3:0]};
		else if (a2 == 2'b01)
			immv = sh6 ? {{9{instr[5]}}, instr[5:0], 1'b0} : {{10{instr[5]}}, instr[5:0]};
		else if (a2 == 2'b10)
			immv = (a1 == 2'b10) ? {{4{instr[10]}}, instr[10:0], 1'b0}
			                     : {{6{instr[8]}}, instr[8:0], 1'b0};
		else if (a2 == 2'b11)
			immv = {{11{instr[4]}}, instr[4:0]};
		else
			immv = 16'd0;
		rd1 = (wb_load && wb_dest == sr1a) ? wb_data : shadow[sr1a];
		rd2 = (wb_load && wb_dest == sr2a) ? wb_data : shadow[sr2a];
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++)
				shadow[i] <= 16'd0;
		end else if (wb_load) begin
			shadow[wb_dest] <= wb_data;
		end
	end

	// Bubble on flush, strobes only for a valid instruction
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n || flush) begin
			exp_valid <= 1'b0;
			exp_read <= 1'b0;
			exp_write <= 1'b0;
			exp_load_regfile <= 1'b0;
			exp_load_cc <= 1'b0;
		end else if (!stall) begin
			exp_valid <= instr_valid;
			exp_read <= rd && instr_valid;
			exp_write <= wr && instr_valid;
			exp_load_regfile <= ldr && instr_valid;
			exp_load_cc <= lcc && instr_valid;
		end
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_alumux1_sel <= 2'b00;
			exp_alumux2_sel <= 2'b00;
			exp_alu_ctrl <= alu_add;
			exp_indirect <= 1'b0;
			exp_mem_byte_sig <= 2'b00;
			exp_regfilemux_sel <= 1'b0;
			exp_memread_sel <= 1'b0;
			exp_pcmux_sel <= 2'b00;
			exp_pcmux_sel_out_sel <= 1'b0;
		end else if (!stall) begin
			exp_alumux1_sel <= a1;
			exp_alumux2_sel <= a2;
			exp_alu_ctrl <= alu;
			exp_indirect <= ind;
			exp_mem_byte_sig <= mbs;
			exp_regfilemux_sel <= rfm;
			exp_memread_sel <= mrs;
			exp_pcmux_sel <= pcm;
			exp_pcmux_sel_out_sel <= pcos;
		end
	end

	always @(posedge clk) begin
		if (!stall) begin
			exp_pc <= pc;
			exp_sr1_data <= rd1;
			exp_sr2_data <= rd2;
			exp_imm <= immv;
			exp_trapvec <= {7'd0, instr[7:0], 1'b0};
			exp_dest <= dsta;
		end
	end

endmodule : id_ref_model

/* testbench/tb_lc3b_id.sv */
`timescale 1ns/100ps

module tb_lc3b_id;

	logic        clk;
	logic        arst_n;
	logic [15:0] instr;
	logic        instr_valid;
	logic [15:0] pc;
	logic        stall;
	logic        flush;
	logic        wb_load;
	logic [2:0]  wb_dest;
	logic [15:0] wb_data;
	logic [31:0] lfsr;
	int          cycles;

	logic        ex_valid;
	logic [15:0] ex_pc;
	logic [15:0] ex_sr1_data;
	logic [15:0] ex_sr2_data;
	logic [15:0] ex_imm;
	logic [15:0] ex_trapvec;
	logic [2:0]  ex_dest;
	logic [1:0]  ex_alumux1_sel;
	logic [1:0]  ex_alumux2_sel;
	logic [2:0]  ex_alu_ctrl;
	logic        ex_indirect;
	logic        ex_read;
	logic        ex_write;
	logic [1:0]  ex_mem_byte_sig;
	logic        ex_regfilemux_sel;
	logic        ex_load_regfile;
	logic        ex_memread_sel;
	logic        ex_load_cc;
	logic [1:0]  ex_pcmux_sel;
	logic        ex_pcmux_sel_out_sel;

	logic        exp_valid;
	logic [15:0] exp_pc;
	logic [15:0] exp_sr1_data;
	logic [15:0] exp_sr2_data;
	logic [15:0] exp_imm;
	logic [15:0] exp_trapvec;
	logic [2:0]  exp_dest;
	logic [1:0]  exp_alumux1_sel;
	logic [1:0]  exp_alumux2_sel;
	logic [2:0]  exp_alu_ctrl;
	logic        exp_indirect;
	logic        exp_read;
	logic        exp_write;
	logic [1:0]  exp_mem_byte_sig;
	logic        exp_regfilemux_sel;
	logic        exp_load_regfile;
	logic        exp_memread_sel;
	logic        exp_load_cc;
	logic [1:0]  exp_pcmux_sel;
	logic        exp_pcmux_sel_out_sel;

	lc3b_id_top uut (
		.clk (clk), .arst_n (arst_n), .instr (instr), .instr_valid (instr_valid),
		.pc (pc), .stall (stall), .flush (flush), .wb_load (wb_load),
		.wb_dest (wb_dest), .wb_data (wb_data), .ex_valid (ex_valid), .ex_pc (ex_pc),
		.ex_sr1_data (ex_sr1_data), .ex_sr2_data (ex_sr2_data), .ex_imm (ex_imm),
		.ex_trapvec (ex_trapvec), .ex_dest (ex_dest), .ex_alumux1_sel (ex_alumux1_sel),
		.ex_alumux2_sel (ex_alumux2_sel), .ex_alu_ctrl (ex_alu_ctrl),
		.ex_indirect (ex_indirect), .ex_read (ex_read), .ex_write (ex_write),
		.ex_mem_byte_sig (ex_mem_byte_sig), .ex_regfilemux_sel (ex_regfilemux_sel),
		.ex_load_regfile (ex_load_regfile), .ex_memread_sel (ex_memread_sel),
		.ex_load_cc (ex_load_cc), .ex_pcmux_sel (ex_pcmux_sel),
		.ex_pcmux_sel_out_sel (ex_pcmux_sel_out_sel)
	);

	id_ref_model model (
		.clk (clk), .arst_n (arst_n), .instr (instr), .instr_valid (instr_valid),
		.pc (pc), .stall (stall), .flush (flush), .wb_load (wb_load),
		.wb_dest (wb_dest), .wb_data (wb_data), .exp_valid (exp_valid), .exp_pc (exp_pc),
		.exp_sr1_data (exp_sr1_data), .exp_sr2_data (exp_sr2_data), .exp_imm (exp_imm),
		.exp_trapvec (exp_trapvec), .exp_dest (exp_dest),
		.exp_alumux1_sel (exp_alumux1_sel), .exp_alumux2_sel (exp_alumux2_sel),
		.exp_alu_ctrl (exp_alu_ctrl), .exp_indirect (exp_indirect), .exp_read (exp_read),
		.exp_write (exp_write), .exp_mem_byte_sig (exp_mem_byte_sig),
		.exp_regfilemux_sel (exp_regfilemux_sel), .exp_load_regfile (exp_load_regfile),
		.exp_memread_sel (exp_memread_sel), .exp_load_cc (exp_load_cc),
		.exp_pcmux_sel (exp_pcmux_sel), .exp_pcmux_sel_out_sel (exp_pcmux_sel_out_sel)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_outputs();
		check_value("ex_valid", 16'(exp_valid), 16'(ex_valid));
		check_value("ex_pc", exp_pc, ex_pc);
		check_value("ex_sr1_data", exp_sr1_data, ex_sr1_data);
		check_value("ex_sr2_data", exp_sr2_data, ex_sr2_data);
		check_value("ex_imm", exp_imm, ex_imm);
		check_value("ex_trapvec", exp_trapvec, ex_trapvec);
		check_value("ex_dest", 16'(exp_dest), 16'(ex_dest));
		check_value("ex_alumux1_sel", 16'(exp_alumux1_sel), 16'(ex_alumux1_sel));
		check_value("ex_alumux2_sel", 16'(exp_alumux2_sel), 16'(ex_alumux2_sel));
		check_value("ex_alu_ctrl", 16'(exp_alu_ctrl), 16'(ex_alu_ctrl));
		check_value("ex_indirect", 16'(exp_indirect), 16'(ex_indirect));
		check_value("ex_read", 16'(exp_read), 16'(ex_read));
		check_value("ex_write", 16'(exp_write), 16'(ex_write));
		check_value("ex_mem_byte_sig", 16'(exp_mem_byte_sig), 16'(ex_mem_byte_sig));
		check_value("ex_regfilemux_sel", 16'(exp_regfilemux_sel), 16'(ex_regfilemux_sel));
		check_value("ex_load_regfile", 16'(exp_load_regfile), 16'(ex_load_regfile));
		check_value("ex_memread_sel", 16'(exp_memread_sel), 16'(ex_memread_sel));
		check_value("ex_load_cc", 16'(exp_load_cc), 16'(ex_load_cc));
		check_value("ex_pcmux_sel", 16'(exp_pcmux_sel), 16'(ex_pcmux_sel));
		check_value("ex_pcmux_sel_out_sel", 16'(exp_pcmux_sel_out_sel),
			16'(ex_pcmux_sel_out_sel));
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		// Upstream holds its instruction while stalled
		if (!stall) begin
			draw_bits(16, r);
			instr = r[15:0];
			draw_bits(16, r);
			pc = r[15:0];
			draw_bits(2, r);
			instr_valid = (r[1:0] != 2'b00);
		end
		draw_bits(3, r);
		stall = (r[2:0] == 3'd0);
		draw_bits(4, r);
		flush = (r[3:0] == 4'd0);
		draw_bits(1, r);
		wb_load = r[0];
		draw_bits(3, r);
		wb_dest = r[2:0];
		draw_bits(16, r);
		wb_data = r[15:0];
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		lfsr = 32'd95128;
		arst_n = 1'b0;
		instr = 16'd0;
		instr_valid = 1'b0;
		pc = 16'd0;
		stall = 1'b0;
		flush = 1'b0;
		wb_load = 1'b0;
		wb_dest = 3'd0;
		wb_data = 16'd0;
		repeat (8) @(posedge clk);
		#2;
		arst_n = 1'b1;
	end

	initial begin
		cycles = 0;
		while (arst_n !== 1'b1) begin
			@(posedge clk or posedge arst_n);
			cycles++;
			if (cycles > 20) begin
				$display("Reset was not released within 20 clock cycles");
				$display("STATUS: FAIL");
				$fatal(1, "Reset timeout");
			end
		end
		// Reset values before the first clock edge after release
		#1;
		check_value("ex_valid", 16'd0, 16'(ex_valid));
		check_value("ex_read", 16'd0, 16'(ex_read));
		check_value("ex_write", 16'd0, 16'(ex_write));
		check_value("ex_load_regfile", 16'd0, 16'(ex_load_regfile));
		check_value("ex_load_cc", 16'd0, 16'(ex_load_cc));
		@(posedge clk);
		#1;
		check_outputs();
		#1;
		drive_inputs();
		repeat (3000) begin
			@(posedge clk);
			#1;
			check_outputs();
			#1;
			drive_inputs();
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule : tb_lc3b_id

/* sim.f */
hw/lc3b_pkg.sv
hw/decode.sv
hw/imm_gen.sv
hw/regfile.sv
hw/id_ex_reg.sv
hw/lc3b_id_top.sv
testbench/id_ref_model.sv
testbench/tb_lc3b_id.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lc3b_id
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
